/* sim.f */
rtl/lfb_addr_pkg.sv
rtl/lfb_pfu_pkg.sv
rtl/lfb_entry_capture.sv
rtl/lfb_entry_refill_ctrl.sv
rtl/lfb_entry_index_match.sv
rtl/lfb_addr_entry.sv
tests/tb_clk_gen.sv
tests/tb_lfb_addr_entry.sv

/* Makefile */
# Verilator build and run for the line-fill buffer address entry

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP        = tb_lfb_addr_entry
FILELIST   = sim.f
LOG        = sim.log
FAIL_MSG   = Simulation failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "sim: failure reported in $(LOG)"; \
		exit 1; \
	fi
	@echo "sim: no failure in $(LOG)"

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_lfb_addr_entry.sv */
/*
  Testbench for the line-fill buffer address entry.
  Drives creates, victim grants, recall results, index probes and pops, and
  checks every output each cycle against a reference model of the entry.
*/

`timescale 1ns/1ps

module tb_lfb_addr_entry;

  typedef struct packed {
    logic                     vld;
    lfb_addr_pkg::line_addr_t line_addr;
    logic                     depd;
    logic                     rcl_done;
    logic                     refill_way;
    logic                     dcache_hit;
    logic                     not_resp;
    logic                     vb_pe_req;
    logic                     pop_vld;
    logic                     discard_vld;
    lfb_pfu_pkg::pfu_vec_t    pfu_hit;
    lfb_pfu_pkg::pfu_vec_t    pfu_miss;
    logic                     permit;
    logic                     abort;
    logic                     ld_hit;
    logic                     st_hit;
  } entry_out_t;

  logic lfb_addr_entry_clk, cpurst_b;
  logic rb_create, pfu_create, lf_sm_pop_req, data_pop_req, rb_atomic, rb_depd;
  logic dcache_en, vb_pe_req_busy, vb_pe_req_permit, vb_pe_req_grnt;
  logic rcl_done_in, vb_dcache_way, vb_dcache_hit, lm_already_snoop, resp_set;
  logic ld_da_discard_grnt;
  lfb_addr_pkg::line_addr_t rb_line_addr, line_addr;
  lfb_addr_pkg::pa_t        pfu_req_addr, st_da_addr;
  lfb_addr_pkg::cache_idx_t ld_da_idx;
  lfb_pfu_pkg::pfu_id_t     pfu_lfb_id;
  logic vld, depd, rcl_done, refill_way, dcache_hit, not_resp, vb_pe_req, pop_vld;
  logic discard_vld, linefill_permit, linefill_abort, ld_da_hit_idx, st_da_hit_idx;
  lfb_pfu_pkg::pfu_vec_t pfu_dcache_hit, pfu_dcache_miss;

  // reference model state
  logic m_vld, m_pfu_created, m_atomic, m_slot, m_rcl, m_way, m_hit;
  logic m_replied, m_resp, m_depd;
  lfb_addr_pkg::line_addr_t m_line;
  lfb_pfu_pkg::pfu_id_t     m_id;

  int seed;
  int errors;
  int checks;
  int tests;
  int failed_tests;
  int errors_at_start;

  tb_clk_gen u_clk_gen (
    .clk   (lfb_addr_entry_clk),
    .rst_b (cpurst_b)
  );

  lfb_addr_entry UUT (.*);

  //==================================================
  // reference model
  //==================================================
  function automatic entry_out_t expected_outputs();
    entry_out_t               e;
    lfb_addr_pkg::cache_idx_t idx;
    lfb_pfu_pkg::pfu_vec_t    onehot;
    logic                     reply;
    idx    = m_line[9:2];
    onehot = '0;
    // ids past the last stream reply nowhere
    if (int'(m_id) < 9)
      onehot[m_id] = 1'b1;
    reply         = m_vld & m_pfu_created & m_rcl & ~m_replied;
    e.vld         = m_vld;
    e.line_addr   = m_line;
    e.depd        = m_depd;
    e.rcl_done    = m_rcl;
    e.refill_way  = m_way;
    e.dcache_hit  = m_hit;
    e.not_resp    = m_vld & ~m_resp;
    e.vb_pe_req   = m_vld & ~m_slot;
    e.pop_vld     = lf_sm_pop_req | data_pop_req;
    e.ld_hit      = m_vld ? (idx == ld_da_idx) : 1'b0;
    e.st_hit      = m_vld ? (idx == st_da_addr[13:6]) : 1'b0;
    e.discard_vld = e.ld_hit & ld_da_discard_grnt;
    e.permit      = m_rcl & (~m_hit | (m_atomic & lm_already_snoop));
    e.abort       = m_rcl & m_hit & (m_pfu_created | (m_atomic & ~lm_already_snoop));
    e.pfu_hit     = (reply & m_hit) ? onehot : '0;
    e.pfu_miss    = (reply & ~m_hit) ? onehot : '0;
    return e;
  endfunction

  // model state at a rising edge
  task automatic advance_model();
    entry_out_t cur;
    logic       create;
    cur    = expected_outputs();
    create = rb_create | pfu_create;
    if (!cpurst_b)
    begin
      {m_vld, m_pfu_created, m_atomic, m_slot, m_rcl, m_way, m_hit} = '0;
      {m_replied, m_resp, m_depd} = '0;
      m_line = '0;
      m_id   = '0;
    end
    else
    begin
      if ((cur.vb_pe_req & vb_pe_req_grnt) || (create & vb_pe_req_permit & ~vb_pe_req_busy))
        m_slot = 1'b1;
      else if (create)
        m_slot = ~dcache_en;
      m_replied = create ? 1'b0 : (m_replied | m_rcl);
      m_resp    = create ? 1'b0 : (m_resp | resp_set);
      if (create)
        {m_rcl, m_way, m_hit} = {~dcache_en, 2'b00};
      else if (rcl_done_in)
        {m_rcl, m_way, m_hit} = {1'b1, vb_dcache_way, vb_dcache_hit};
      if (rb_create)
      begin
        m_line        = rb_line_addr;
        m_id          = '0;
        m_pfu_created = 1'b0;
        m_atomic      = rb_atomic;
        m_depd        = rb_depd;
      end
      else if (pfu_create)
      begin
        m_line        = pfu_req_addr[39:4];
        m_id          = pfu_lfb_id;
        m_pfu_created = 1'b1;
        m_atomic      = 1'b0;
        m_depd        = 1'b0;
      end
      else if (cur.discard_vld)
        m_depd = 1'b1;
      // pop beats create
      if (cur.pop_vld)
        m_vld = 1'b0;
      else if (create)
        m_vld = 1'b1;
    end
  endtask

  //==================================================
  // comparing process
  //==================================================
  task automatic compare_field(input string name, input logic [39:0] got,
                               input logic [39:0] want);
    checks++;
    assert (got === want)
    else
    begin
      errors++;
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic compare_outputs();
    entry_out_t e;
    e = expected_outputs();
    compare_field("vld", 40'(vld), 40'(e.vld));
    compare_field("line_addr", 40'(line_addr), 40'(e.line_addr));
    compare_field("depd", 40'(depd), 40'(e.depd));
    compare_field("rcl_done", 40'(rcl_done), 40'(e.rcl_done));
    compare_field("refill_way", 40'(refill_way), 40'(e.refill_way));
    compare_field("dcache_hit", 40'(dcache_hit), 40'(e.dcache_hit));
    compare_field("not_resp", 40'(not_resp), 40'(e.not_resp));
    compare_field("vb_pe_req", 40'(vb_pe_req), 40'(e.vb_pe_req));
    compare_field("pop_vld", 40'(pop_vld), 40'(e.pop_vld));
    compare_field("discard_vld", 40'(discard_vld), 40'(e.discard_vld));
    compare_field("pfu_dcache_hit", 40'(pfu_dcache_hit), 40'(e.pfu_hit));
    compare_field("pfu_dcache_miss", 40'(pfu_dcache_miss), 40'(e.pfu_miss));
    compare_field("linefill_permit", 40'(linefill_permit), 40'(e.permit));
    compare_field("linefill_abort", 40'(linefill_abort), 40'(e.abort));
    compare_field("ld_da_hit_idx", 40'(ld_da_hit_idx), 40'(e.ld_hit));
    compare_field("st_da_hit_idx", 40'(st_da_hit_idx), 40'(e.st_hit));
  endtask

  // compare 1 ns after the edge once outputs have settled
  always @(posedge lfb_addr_entry_clk)
  begin
    advance_model();
    #1;
    if (cpurst_b)
      compare_outputs();
  end

  //==================================================
  // stimulus helpers
  //==================================================
  function automatic lfb_addr_pkg::line_addr_t random_line();
    return 36'({$random(seed), $random(seed)});
  endfunction

  function automatic logic probe(input string name);
    case (name)
      "rst":       return cpurst_b;
      "vld":       return vld;
      "depd":      return depd;
      "vb_pe_req": return vb_pe_req;
      "rcl_done":  return rcl_done;
      "not_resp":  return not_resp;
      "permit":    return linefill_permit;
      "abort":     return linefill_abort;
      "pfu_hit":   return |pfu_dcache_hit;
      "pfu_miss":  return |pfu_dcache_miss;
      default:     return 1'b0;
    endcase
  endfunction

  // poll after each rising edge and give up after 20 cycles
  task automatic wait_for(input string name, input logic level);
    for (int n = 0; n < 20; n++)
    begin
      @(posedge lfb_addr_entry_clk);
      #2;
      if (probe(name) === level)
        return;
    end
    $display("timeout: %s did not reach %0b within 20 cycles", name, level);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic create_rb(input lfb_addr_pkg::line_addr_t addr, input logic atm,
                           input logic dep);
    @(negedge lfb_addr_entry_clk);
    rb_create    = 1'b1;
    rb_line_addr = addr;
    rb_atomic    = atm;
    rb_depd      = dep;
    @(negedge lfb_addr_entry_clk);
    rb_create = 1'b0;
    wait_for("vld", 1'b1);
  endtask

  task automatic create_pfu(input lfb_pfu_pkg::pfu_id_t id);
    @(negedge lfb_addr_entry_clk);
    pfu_create   = 1'b1;
    pfu_req_addr = 40'({$random(seed), $random(seed)});
    pfu_lfb_id   = id;
    @(negedge lfb_addr_entry_clk);
    pfu_create = 1'b0;
    wait_for("vld", 1'b1);
  endtask

  // recall done held until the watched output answers
  task automatic recall(input logic hit, input string watch);
    @(negedge lfb_addr_entry_clk);
    rcl_done_in   = 1'b1;
    vb_dcache_hit = hit;
    vb_dcache_way = 1'($random(seed));
    wait_for(watch, 1'b1);
    @(negedge lfb_addr_entry_clk);
    rcl_done_in = 1'b0;
  endtask

  task automatic pop_entry(input logic use_data);
    @(negedge lfb_addr_entry_clk);
    lf_sm_pop_req = ~use_data;
    data_pop_req  = use_data;
    @(negedge lfb_addr_entry_clk);
    {lf_sm_pop_req, data_pop_req} = 2'b00;
    wait_for("vld", 1'b0);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_at_start)
      $display("test %0d %s: ok", tests, name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  //==================================================
  // tests
  //==================================================
  initial
  begin
    lfb_addr_pkg::line_addr_t line;
    string                    watch;
    seed            = 32'h854e47e5;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    failed_tests    = 0;
    errors_at_start = 0;
    {rb_create, pfu_create, lf_sm_pop_req, data_pop_req, rb_atomic, rb_depd} = '0;
    {vb_pe_req_busy, vb_pe_req_permit, vb_pe_req_grnt, rcl_done_in} = '0;
    {vb_dcache_way, vb_dcache_hit, lm_already_snoop, resp_set} = '0;
    ld_da_discard_grnt = 1'b0;
    dcache_en          = 1'b1;
    rb_line_addr       = '0;
    pfu_req_addr       = '0;
    pfu_lfb_id         = '0;
    ld_da_idx          = '0;
    st_da_addr         = '0;
    wait_for("rst", 1'b1);

    // victim request held until granted
    create_rb(random_line(), 1'b0, 1'b0);
    repeat (3) @(negedge lfb_addr_entry_clk);
    vb_pe_req_grnt = 1'b1;
    @(negedge lfb_addr_entry_clk);
    vb_pe_req_grnt = 1'b0;
    wait_for("vb_pe_req", 1'b0);
    pop_entry(1'b0);
    @(negedge lfb_addr_entry_clk);
    vb_pe_req_permit = 1'b1;
    create_rb(random_line(), 1'b0, 1'b0);
    repeat (3) @(negedge lfb_addr_entry_clk);
    pop_entry(1'b1);
    // another entry asking blocks the immediate slot
    @(negedge lfb_addr_entry_clk);
    vb_pe_req_busy = 1'b1;
    create_rb(random_line(), 1'b0, 1'b0);
    wait_for("vb_pe_req", 1'b1);
    @(negedge lfb_addr_entry_clk);
    vb_pe_req_busy = 1'b0;
    vb_pe_req_grnt = 1'b1;
    @(negedge lfb_addr_entry_clk);
    vb_pe_req_grnt = 1'b0;
    wait_for("vb_pe_req", 1'b0);
    pop_entry(1'b1);
    end_test("victim handshake");

    // one-hot reply, hit then miss
    for (int k = 0; k < 2; k++)
    begin
      watch = (k == 0) ? "pfu_hit" : "pfu_miss";
      create_pfu(4'($unsigned($random(seed)) % 9));
      recall(k == 0, watch);
      wait_for(watch, 1'b0);
      pop_entry(k[0]);
    end
    end_test("prefetch reply");

    @(negedge lfb_addr_entry_clk);
    lm_already_snoop = 1'b1;
    create_rb(random_line(), 1'b1, 1'b0);
    recall(1'b1, "permit");
    @(negedge lfb_addr_entry_clk);
    lm_already_snoop = 1'b0;
    wait_for("abort", 1'b1);
    pop_entry(1'b0);
    end_test("atomic decision");

    // recall skipped, no victim slot needed
    @(negedge lfb_addr_entry_clk);
    dcache_en        = 1'b0;
    vb_pe_req_permit = 1'b0;
    create_rb(random_line(), 1'b0, 1'b0);
    wait_for("rcl_done", 1'b1);
    wait_for("permit", 1'b1);
    pop_entry(1'b1);
    @(negedge lfb_addr_entry_clk);
    dcache_en        = 1'b1;
    vb_pe_req_permit = 1'b1;
    end_test("dcache disabled");

    line = random_line();
    create_rb(line, 1'b0, 1'b0);
    for (int k = 0; k < 16; k++)
    begin
      @(negedge lfb_addr_entry_clk);
      ld_da_idx  = k[0] ? line[9:2] : 8'($random(seed));
      st_da_addr = k[1] ? {26'($random(seed)), line[9:2], 6'($random(seed))}
                        : 40'({$random(seed), $random(seed)});
    end
    @(negedge lfb_addr_entry_clk);
    ld_da_idx          = line[9:2];
    ld_da_discard_grnt = 1'b1;
    @(negedge lfb_addr_entry_clk);
    ld_da_discard_grnt = 1'b0;
    wait_for("depd", 1'b1);
    pop_entry(1'b0);
    create_rb(random_line(), 1'b0, 1'b0);
    wait_for("depd", 1'b0);
    pop_entry(1'b1);
    create_rb(random_line(), 1'b0, 1'b1);
    wait_for("depd", 1'b1);
    pop_entry(1'b0);
    end_test("index and dependency");

    line = random_line();
    create_rb(line, 1'b0, 1'b0);
    repeat (3) @(negedge lfb_addr_entry_clk);
    resp_set = 1'b1;
    @(negedge lfb_addr_entry_clk);
    resp_set = 1'b0;
    wait_for("not_resp", 1'b0);
    pop_entry(1'b0);
    // pop and create together on a valid entry with both hits up
    create_rb(line, 1'b0, 1'b0);
    @(negedge lfb_addr_entry_clk);
    ld_da_idx  = line[9:2];
    st_da_addr = {26'($random(seed)), line[9:2], 6'($random(seed))};
    @(negedge lfb_addr_entry_clk);
    rb_create    = 1'b1;
    rb_line_addr = line;
    data_pop_req = 1'b1;
    @(negedge lfb_addr_entry_clk);
    rb_create    = 1'b0;
    data_pop_req = 1'b0;
    wait_for("vld", 1'b0);
    end_test("response and pop");

    repeat (2) @(negedge lfb_addr_entry_clk);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0 && failed_tests == 0 && checks > 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* tests/tb_clk_gen.sv */
/*
  Clock and reset source for the line-fill buffer entry testbench.
  8 ns free-running clock, reset held low for the first 4 cycles.
*/

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_b
);

  initial
  begin
    clk   = 1'b0;
    rst_b = 1'b0;
    // release on a falling edge, away from the sampling edge
    #32;
    rst_b = 1'b1;
  end

  always #4 clk = ~clk;

endmodule

/* rtl/lfb_addr_entry.sv */
/*
  One address entry of the dcache line-fill buffer.
  Joins create capture, refill control and index compare into one entry.
*/

`timescale 1ns/1ps

module lfb_addr_entry (
  input  logic                     lfb_addr_entry_clk,
  input  logic                     cpurst_b,
  input  logic                     rb_create,
  input  logic                     pfu_create,
  input  logic                     lf_sm_pop_req,
  input  logic                     data_pop_req,
  input  lfb_addr_pkg::line_addr_t rb_line_addr,
  input  logic                     rb_atomic,
  input  logic                     rb_depd,
  input  lfb_addr_pkg::pa_t        pfu_req_addr,
  input  lfb_pfu_pkg::pfu_id_t     pfu_lfb_id,
  input  logic                     dcache_en,
  input  logic                     vb_pe_req_busy,
  input  logic                     vb_pe_req_permit,
  input  logic                     vb_pe_req_grnt,
  input  logic                     rcl_done_in,
  input  logic                     vb_dcache_way,
  input  logic                     vb_dcache_hit,
  input  logic                     lm_already_snoop,
  input  logic                     resp_set,
  input  lfb_addr_pkg::cache_idx_t ld_da_idx,
  input  lfb_addr_pkg::pa_t        st_da_addr,
  input  logic                     ld_da_discard_grnt,
  output logic                     vld,
  output lfb_addr_pkg::line_addr_t line_addr,
  output logic                     depd,
  output logic                     rcl_done,
  output logic                     refill_way,
  output logic                     dcache_hit,
  output logic                     not_resp,
  output logic                     vb_pe_req,
  output logic                     pop_vld,
  output logic                     discard_vld,
  output lfb_pfu_pkg::pfu_vec_t    pfu_dcache_hit,
  output lfb_pfu_pkg::pfu_vec_t    pfu_dcache_miss,
  output logic                     linefill_permit,
  output logic                     linefill_abort,
  output logic                     ld_da_hit_idx,
  output logic                     st_da_hit_idx
);

  logic                 create;
  logic                 rb_create_q;
  logic                 pfu_created;
  logic                 atomic;
  lfb_pfu_pkg::pfu_id_t pfu_id;

  //==================================================
  // create capture
  //==================================================
  lfb_entry_capture u_capture (
    .lfb_addr_entry_clk (lfb_addr_entry_clk),
    .cpurst_b           (cpurst_b),
    .rb_create          (rb_create),
    .pfu_create         (pfu_create),
    .lf_sm_pop_req      (lf_sm_pop_req),
    .data_pop_req       (data_pop_req),
    .rb_line_addr       (rb_line_addr),
    .rb_atomic          (rb_atomic),
    .pfu_req_addr       (pfu_req_addr),
    .pfu_lfb_id         (pfu_lfb_id),
    .vld                (vld),
    .create             (create),
    .rb_create_q        (rb_create_q),
    .pfu_created        (pfu_created),
    .atomic             (atomic),
    .pop_vld            (pop_vld),
    .pfu_id             (pfu_id),
    .line_addr          (line_addr)
  );

  //==================================================
  // refill control
  //==================================================
  lfb_entry_refill_ctrl u_refill_ctrl (
    .lfb_addr_entry_clk (lfb_addr_entry_clk),
    .cpurst_b           (cpurst_b),
    .vld                (vld),
    .create             (create),
    .pfu_created        (pfu_created),
    .atomic             (atomic),
    .pfu_id             (pfu_id),
    .dcache_en          (dcache_en),
    .vb_pe_req_busy     (vb_pe_req_busy),
    .vb_pe_req_permit   (vb_pe_req_permit),
    .vb_pe_req_grnt     (vb_pe_req_grnt),
    .rcl_done_in        (rcl_done_in),
    .vb_dcache_way      (vb_dcache_way),
    .vb_dcache_hit      (vb_dcache_hit),
    .lm_already_snoop   (lm_already_snoop),
    .resp_set           (resp_set),
    .vb_pe_req          (vb_pe_req),
    .rcl_done           (rcl_done),
    .refill_way         (refill_way),
    .dcache_hit         (dcache_hit),
    .linefill_permit    (linefill_permit),
    .linefill_abort     (linefill_abort),
    .not_resp           (not_resp),
    .pfu_dcache_hit     (pfu_dcache_hit),
    .pfu_dcache_miss    (pfu_dcache_miss)
  );

  //==================================================
  // index compare
  //==================================================
  // prefetch create pulse straight from the port
  lfb_entry_index_match u_index_match (
    .lfb_addr_entry_clk (lfb_addr_entry_clk),
    .cpurst_b           (cpurst_b),
    .vld                (vld),
    .line_addr          (line_addr),
    .pfu_create         (pfu_create),
    .rb_create          (rb_create_q),
    .rb_depd            (rb_depd),
    .ld_da_idx          (ld_da_idx),
    .st_da_addr         (st_da_addr),
    .ld_da_discard_grnt (ld_da_discard_grnt),
    .ld_da_hit_idx      (ld_da_hit_idx),
    .st_da_hit_idx      (st_da_hit_idx),
    .discard_vld        (discard_vld),
    .depd               (depd)
  );

endmodule

/* rtl/lfb_entry_index_match.sv */
/*
  Output side of the line-fill buffer address entry.
  Compares the entry's set index with the load and store data-access stages
  and keeps the dependency flag raised by a discard grant on a load hit.
*/

`timescale 1ns/1ps

module lfb_entry_index_match (
  input  logic                     lfb_addr_entry_clk,
  input  logic                     cpurst_b,
  input  logic                     vld,
  input  lfb_addr_pkg::line_addr_t line_addr,
  input  logic                     pfu_create,
  input  logic                     rb_create,
  input  logic                     rb_depd,
  input  lfb_addr_pkg::cache_idx_t ld_da_idx,
  input  lfb_addr_pkg::pa_t        st_da_addr,
  input  logic                     ld_da_discard_grnt,
  output logic                     ld_da_hit_idx,
  output logic                     st_da_hit_idx,
  output logic                     discard_vld,
  output logic                     depd
);

  lfb_addr_pkg::cache_idx_t entry_idx;
  lfb_addr_pkg::cache_idx_t st_idx;

  //==================================================
  // index compare
  //==================================================
  assign entry_idx = line_addr[lfb_addr_pkg::line_idx_lsb +: $bits(lfb_addr_pkg::cache_idx_t)];
  assign st_idx    = st_da_addr[lfb_addr_pkg::pa_idx_lsb +: $bits(lfb_addr_pkg::cache_idx_t)];

  assign ld_da_hit_idx = vld & (entry_idx == ld_da_idx);
  assign st_da_hit_idx = vld & (entry_idx == st_idx);

  // load dropped on our index
  assign discard_vld = ld_da_hit_idx & ld_da_discard_grnt;

  //==================================================
  // dependency flag
  //==================================================
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      depd <= 1'b0;
    else if (rb_create)
      depd <= rb_depd;
    else if (pfu_create)
      depd <= 1'b0;
    else if (discard_vld)
      depd <= 1'b1;
  end

endmodule

/* rtl/lfb_entry_refill_ctrl.sv */
/*
  Refill control of the line-fill buffer address entry.
  Requests a victim slot, records the recall result, decides linefill permit
  or abort, tracks the bus response and sends the one-shot prefetch reply.
*/

`timescale 1ns/1ps

module lfb_entry_refill_ctrl (
  input  logic                  lfb_addr_entry_clk,
  input  logic                  cpurst_b,
  input  logic                  vld,
  input  logic                  create,
  input  logic                  pfu_created,
  input  logic                  atomic,
  input  lfb_pfu_pkg::pfu_id_t  pfu_id,
  input  logic                  dcache_en,
  input  logic                  vb_pe_req_busy,
  input  logic                  vb_pe_req_permit,
  input  logic                  vb_pe_req_grnt,
  input  logic                  rcl_done_in,
  input  logic                  vb_dcache_way,
  input  logic                  vb_dcache_hit,
  input  logic                  lm_already_snoop,
  input  logic                  resp_set,
  output logic                  vb_pe_req,
  output logic                  rcl_done,
  output logic                  refill_way,
  output logic                  dcache_hit,
  output logic                  linefill_permit,
  output logic                  linefill_abort,
  output logic                  not_resp,
  output lfb_pfu_pkg::pfu_vec_t pfu_dcache_hit,
  output lfb_pfu_pkg::pfu_vec_t pfu_dcache_miss
);

  logic                  vb_slot_done;
  logic                  vb_slot_set;
  logic                  already_reply;
  logic                  resp;
  logic                  atomic_abort;
  logic                  reply_vld;
  lfb_pfu_pkg::pfu_vec_t pfu_id_oh;

  //==================================================
  // victim buffer request
  //==================================================
  assign vb_pe_req = vld & ~vb_slot_done;

  // slot given at once when nobody else asks, or by a grant later
  assign vb_slot_set = (create & vb_pe_req_permit & ~vb_pe_req_busy)
                     | (vb_pe_req & vb_pe_req_grnt);

  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vb_slot_done <= 1'b0;
    else if (vb_slot_set)
      vb_slot_done <= 1'b1;
    else if (create)
      vb_slot_done <= ~dcache_en;
  end

  //==================================================
  // recall result and response
  //==================================================
  // dcache off skips the recall entirely
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rcl_done   <= 1'b0;
      refill_way <= 1'b0;
      dcache_hit <= 1'b0;
    end
    else if (create)
    begin
      rcl_done   <= ~dcache_en;
      refill_way <= 1'b0;
      dcache_hit <= 1'b0;
    end
    else if (rcl_done_in)
    begin
      rcl_done   <= 1'b1;
      refill_way <= vb_dcache_way;
      dcache_hit <= vb_dcache_hit;
    end
  end

  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      already_reply <= 1'b0;
      resp          <= 1'b0;
    end
    else if (create)
    begin
      already_reply <= 1'b0;
      resp          <= 1'b0;
    end
    else
    begin
      already_reply <= already_reply | rcl_done;
      resp          <= resp | resp_set;
    end
  end

  assign not_resp = vld & ~resp;

  //==================================================
  // linefill decision
  //==================================================
  assign atomic_abort    = dcache_hit & ~lm_already_snoop;
  assign linefill_permit = rcl_done & (~dcache_hit | (atomic & ~atomic_abort));
  assign linefill_abort  = rcl_done & dcache_hit & (pfu_created | (atomic & atomic_abort));

  //==================================================
  // prefetch reply
  //==================================================
  always_comb
  begin
    for (int i = 0; i < lfb_pfu_pkg::pfu_streams; i++)
      pfu_id_oh[i] = (pfu_id == lfb_pfu_pkg::pfu_id_t'(i));
  end

  // first cycle of rcl_done only
  assign reply_vld = vld & pfu_created & rcl_done & ~already_reply;

  assign pfu_dcache_hit  = {lfb_pfu_pkg::pfu_streams{reply_vld & dcache_hit}} & pfu_id_oh;
  assign pfu_dcache_miss = {lfb_pfu_pkg::pfu_streams{reply_vld & ~dcache_hit}} & pfu_id_oh;

endmodule

/* rtl/lfb_entry_capture.sv */
/*
  Input side of the line-fill buffer address entry.
  Holds the valid flag and loads the line address, source, atomic flag and
  prefetch id when the read buffer or the prefetch unit creates the entry.
*/

`timescale 1ns/1ps

module lfb_entry_capture (
  input  logic                     lfb_addr_entry_clk,
  input  logic                     cpurst_b,
  input  logic                     rb_create,
  input  logic                     pfu_create,
  input  logic                     lf_sm_pop_req,
  input  logic                     data_pop_req,
  input  lfb_addr_pkg::line_addr_t rb_line_addr,
  input  logic                     rb_atomic,
  input  lfb_addr_pkg::pa_t        pfu_req_addr,
  input  lfb_pfu_pkg::pfu_id_t     pfu_lfb_id,
  output logic                     vld,
  output logic                     create,
  output logic                     rb_create_q,
  output logic                     pfu_created,
  output logic                     atomic,
  output logic                     pop_vld,
  output lfb_pfu_pkg::pfu_id_t     pfu_id,
  output lfb_addr_pkg::line_addr_t line_addr
);

  //==================================================
  // create and pop decode
  //==================================================
  assign create      = rb_create | pfu_create;
  assign rb_create_q = rb_create;
  assign pop_vld     = lf_sm_pop_req | data_pop_req;

  // pop has priority over a create in the same cycle
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld <= 1'b0;
    else if (pop_vld)
      vld <= 1'b0;
    else if (create)
      vld <= 1'b1;
  end

  //==================================================
  // create-time fields
  //==================================================
  // read buffer wins the source and atomic flag
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pfu_created <= 1'b0;
      atomic      <= 1'b0;
    end
    else if (rb_create)
    begin
      pfu_created <= 1'b0;
      atomic      <= rb_atomic;
    end
    else if (pfu_create)
    begin
      pfu_created <= 1'b1;
      atomic      <= 1'b0;
    end
  end

  // line address and stream id
  always_ff @(posedge lfb_addr_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      line_addr <= '0;
      pfu_id    <= '0;
    end
    else if (rb_create)
    begin
      line_addr <= rb_line_addr;
      pfu_id    <= '0;
    end
    else if (pfu_create)
    begin
      line_addr <= pfu_req_addr[lfb_addr_pkg::pa_width-1:4];
      pfu_id    <= pfu_lfb_id;
    end
  end

endmodule

/* rtl/lfb_pfu_pkg.sv */
/*
  Prefetch unit types seen by a line-fill buffer entry.
  Covers the stream id captured at create and the one-hot hit and miss reply.
*/

package lfb_pfu_pkg;

  //==================================================
  // prefetch streams
  //==================================================
  localparam int pfu_streams = 9;

  // ids at or above pfu_streams map to no reply bit
  typedef logic [3:0] pfu_id_t;

  // one bit per stream
  typedef logic [pfu_streams-1:0] pfu_vec_t;

endpackage

/* rtl/lfb_addr_pkg.sv */
/*
  Physical address widths and vector types for one line-fill buffer address entry.
  Used by the create capture, the index compare and the entry top.
*/

package lfb_addr_pkg;

  //==================================================
  // address widths
  //==================================================
  localparam int pa_width = 40;

  // lowest set-index bit inside a line address
  localparam int line_idx_lsb = 2;

  // lowest set-index bit inside a full physical address
  localparam int pa_idx_lsb = 6;

  //==================================================
  // vector types
  //==================================================
  typedef logic [pa_width-1:0] pa_t;

  // address bits 39 down to 4 of a 16-byte line
  typedef logic [pa_width-5:0] line_addr_t;

  // dcache set index
  typedef logic [7:0] cache_idx_t;

endpackage
